// ==== hdl/exe_cfg.svh ====
/*
 * Build-time sizes for the execute cluster.
 * Included by every RTL file that takes a width or a lane count from it.
 */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// Operand and result width.
`define EXE_DATA_LEN 32

// Register file address width for the writeback index.
`define EXE_REG_ADDR_W 5

// Number of parallel execute lanes. 2 and 4 are supported.
`define EXE_NUM_LANES 2

// Width of the issue and retire pointers.
`define EXE_LANE_IDX_W $clog2(`EXE_NUM_LANES)

// Extra cycles the testbench watchdog grants beyond its per-operation budget.
`define EXE_WDOG_MARGIN 200

`endif

// ==== hdl/exe_pkg.sv ====
/*
 * Encodings shared by the decoder side and the execute cluster.
 * Modules name these types in their ports and import the package in their body.
 */
package exe_pkg;

	// ALU operation select.
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SLL   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_SLT   = 4'd8,
		ALU_SLTU  = 4'd9,
		ALU_COPY2 = 4'd10 // Source 2 passes straight through.
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3 // Link address step for jal and jalr.
	} src2_sel_e;

	typedef enum logic [2:0] {
		BRANCH_NONE = 3'd0,
		BRANCH_BEQ  = 3'd1,
		BRANCH_BNE  = 3'd2,
		BRANCH_BLT  = 3'd3,
		BRANCH_BGE  = 3'd4,
		BRANCH_BLTU = 3'd5,
		BRANCH_BGEU = 3'd6
	} branch_e;

	typedef enum logic [1:0] {
		CSR_NONE = 2'd0,
		CSR_RW   = 2'd1,
		CSR_RS   = 2'd2
	} csr_op_e;

	// Load width and sign. Zero means the op is no load.
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0, LOAD_LB = 3'd1, LOAD_LH = 3'd2, LOAD_LW = 3'd3,
		LOAD_LBU  = 3'd4, LOAD_LHU = 3'd5
	} load_e;

	// Store width. Zero means the op is no store.
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0, STORE_SB = 2'd1, STORE_SH = 2'd2, STORE_SW = 2'd3
	} store_e;

endpackage

// ==== hdl/exe_alu.sv ====
/*
 * RV32I integer ALU, purely combinational.
 * The lane feeds it the selected sources and uses less_o and zero_o for branches.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_alu #(
	parameter int DATA_LEN = `EXE_DATA_LEN
) (
	input  logic [DATA_LEN-1:0] src1_i,
	input  logic [DATA_LEN-1:0] src2_i,
	input  exe_pkg::alu_op_e    alu_op_i,
	output logic [DATA_LEN-1:0] result_o,
	output logic                less_o,
	output logic                zero_o
);
	import exe_pkg::*;

	localparam int SHAMT_W = $clog2(DATA_LEN);

	logic               less_s;
	logic               less_u;
	logic [SHAMT_W-1:0] shamt;

	assign less_s = $signed(src1_i) < $signed(src2_i);
	assign less_u = src1_i < src2_i;
	assign shamt  = src2_i[SHAMT_W-1:0]; // Only the low bits count.

	always_comb begin
		case (alu_op_i)
			ALU_ADD:   result_o = src1_i + src2_i;
			ALU_SUB:   result_o = src1_i - src2_i;
			ALU_AND:   result_o = src1_i & src2_i;
			ALU_OR:    result_o = src1_i | src2_i;
			ALU_XOR:   result_o = src1_i ^ src2_i;
			ALU_SLL:   result_o = src1_i << shamt;
			ALU_SRL:   result_o = src1_i >> shamt;
			ALU_SRA:   result_o = DATA_LEN'($signed(src1_i) >>> shamt);
			ALU_SLT:   result_o = DATA_LEN'(less_s);
			ALU_SLTU:  result_o = DATA_LEN'(less_u);
			ALU_COPY2: result_o = src2_i;
			default:   result_o = '0;
		endcase
	end

	// Unsigned compare only for SLTU, which the decoder picks for BLTU and BGEU.
	assign less_o = (alu_op_i == ALU_SLTU) ? less_u : less_s;

	// With SUB this is the equality test.
	assign zero_o = (result_o == '0);

endmodule

// ==== hdl/exe_lane.sv ====
/*
 * One execute lane: source muxes, ALU, branch resolve, CSR and store fields.
 * Results sit in a one-entry holding register until the retire stage takes them.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_lane #(
	parameter int DATA_LEN = `EXE_DATA_LEN,
	parameter int REG_W    = `EXE_REG_ADDR_W
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                valid_i,
	output logic                ready_o,
	input  logic [DATA_LEN-1:0] reg1_i,
	input  logic [DATA_LEN-1:0] reg2_i,
	input  logic [DATA_LEN-1:0] pc_i,
	input  logic [DATA_LEN-1:0] imm_i,
	input  logic [DATA_LEN-1:0] csr_rdata_i,
	input  exe_pkg::alu_op_e    alu_op_i,
	input  exe_pkg::src1_sel_e  src1_sel_i,
	input  exe_pkg::src2_sel_e  src2_sel_i,
	input  exe_pkg::branch_e    branch_i,
	input  exe_pkg::csr_op_e    csr_op_i,
	input  exe_pkg::load_e      load_i,
	input  exe_pkg::store_e     store_i,
	input  logic                wd_i,
	input  logic [REG_W-1:0]    wreg_i,
	output logic                res_valid_o,
	input  logic                res_ready_i,
	output logic [DATA_LEN-1:0] alu_result_o,
	output logic                branch_taken_o,
	output logic                mem_wen_o,
	output logic [DATA_LEN-1:0] mem_wdata_o,
	output logic [DATA_LEN-1:0] csr_wdata_o,
	output exe_pkg::load_e      load_o,
	output exe_pkg::store_e     store_o,
	output logic                wd_o,
	output logic [REG_W-1:0]    wreg_o
);
	import exe_pkg::*;

	logic [DATA_LEN-1:0] src1;
	logic [DATA_LEN-1:0] src2;
	logic [DATA_LEN-1:0] alu_result;
	logic                alu_less;
	logic                alu_zero;
	logic                branch_taken;
	logic [DATA_LEN-1:0] csr_wdata;
	logic                accept;

	always_comb begin
		case (src1_sel_i)
			SRC1_REG1: src1 = reg1_i;
			SRC1_PC:   src1 = pc_i;
			SRC1_CSR:  src1 = csr_rdata_i;
			default:   src1 = '0;
		endcase
		case (src2_sel_i)
			SRC2_REG2: src2 = reg2_i;
			SRC2_IMM:  src2 = imm_i;
			SRC2_FOUR: src2 = DATA_LEN'(4);
			default:   src2 = '0;
		endcase
	end

	exe_alu #(.DATA_LEN(DATA_LEN)) alu_i (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (alu_op_i),
		.result_o (alu_result),
		.less_o   (alu_less),
		.zero_o   (alu_zero)
	);

	// Flags come from whichever compare the decoder put in alu_op_i.
	always_comb begin
		case (branch_i)
			BRANCH_BEQ:  branch_taken = alu_zero;
			BRANCH_BNE:  branch_taken = ~alu_zero;
			BRANCH_BLT:  branch_taken = alu_less;
			BRANCH_BGE:  branch_taken = ~alu_less;
			BRANCH_BLTU: branch_taken = alu_less;
			BRANCH_BGEU: branch_taken = ~alu_less;
			default:     branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (csr_op_i)
			CSR_RW:  csr_wdata = reg1_i;
			CSR_RS:  csr_wdata = reg1_i | csr_rdata_i; // Set bits.
			default: csr_wdata = '0;
		endcase
	end

	// Free slot, or the held result leaves on this edge.
	assign ready_o = ~res_valid_o | res_ready_i;
	assign accept  = valid_i & ready_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_valid_o <= 1'b0;
		end else if (accept) begin
			res_valid_o <= 1'b1;
		end else if (res_ready_i) begin
			res_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			alu_result_o   <= alu_result;
			branch_taken_o <= branch_taken;
			mem_wen_o      <= (store_i != STORE_NONE);
			mem_wdata_o    <= reg2_i;
			csr_wdata_o    <= csr_wdata;
			load_o         <= load_i;
			store_o        <= store_i;
			wd_o           <= wd_i;
			wreg_o         <= wreg_i;
		end
	end

endmodule

// ==== hdl/exe_dispatch.sv ====
/*
 * Round-robin issue of incoming operations to the execute lanes.
 * Only the lane under the issue pointer sees valid; its ready goes back upstream.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_dispatch #(
	parameter int NUM_LANES = `EXE_NUM_LANES,
	parameter int IDX_W     = `EXE_LANE_IDX_W
) (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 in_valid_i,
	output logic                 in_ready_o,
	output logic [NUM_LANES-1:0] lane_valid_o,
	input  logic [NUM_LANES-1:0] lane_ready_i
);
	logic [IDX_W-1:0] issue_ptr_q;
	logic             issue;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_valid_o[i] = in_valid_i && (issue_ptr_q == IDX_W'(i));
		end
	end

	assign in_ready_o = lane_ready_i[issue_ptr_q];
	assign issue      = in_valid_i & in_ready_o;

	// Next lane after every accepted op.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			issue_ptr_q <= '0;
		end else if (issue) begin
			if (issue_ptr_q == IDX_W'(NUM_LANES - 1)) begin
				issue_ptr_q <= '0;
			end else begin
				issue_ptr_q <= issue_ptr_q + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/exe_retire.sv ====
/*
 * In-order collection of lane results onto the single output port.
 * Walks the lanes in the same round-robin order the dispatcher used.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_retire #(
	parameter int DATA_LEN  = `EXE_DATA_LEN,
	parameter int REG_W     = `EXE_REG_ADDR_W,
	parameter int NUM_LANES = `EXE_NUM_LANES,
	parameter int IDX_W     = `EXE_LANE_IDX_W
) (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic [NUM_LANES-1:0] res_valid_i,
	output logic [NUM_LANES-1:0] res_ready_o,
	input  logic [DATA_LEN-1:0]  res_alu_result_i   [NUM_LANES],
	input  logic                 res_branch_taken_i [NUM_LANES],
	input  logic                 res_mem_wen_i      [NUM_LANES],
	input  logic [DATA_LEN-1:0]  res_mem_wdata_i    [NUM_LANES],
	input  logic [DATA_LEN-1:0]  res_csr_wdata_i    [NUM_LANES],
	input  exe_pkg::load_e       res_load_i         [NUM_LANES],
	input  exe_pkg::store_e      res_store_i        [NUM_LANES],
	input  logic                 res_wd_i           [NUM_LANES],
	input  logic [REG_W-1:0]     res_wreg_i         [NUM_LANES],
	output logic                 out_valid_o,
	input  logic                 out_ready_i,
	output logic [DATA_LEN-1:0]  alu_result_o,
	output logic                 branch_taken_o,
	output logic                 mem_wen_o,
	output logic [DATA_LEN-1:0]  mem_wdata_o,
	output logic [DATA_LEN-1:0]  csr_wdata_o,
	output exe_pkg::load_e       load_o,
	output exe_pkg::store_e      store_o,
	output logic                 wd_o,
	output logic [REG_W-1:0]     wreg_o
);
	logic [IDX_W-1:0] retire_ptr_q;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			res_ready_o[i] = out_ready_i && (retire_ptr_q == IDX_W'(i));
		end
	end

	assign out_valid_o    = res_valid_i[retire_ptr_q];
	assign alu_result_o   = res_alu_result_i[retire_ptr_q];
	assign branch_taken_o = res_branch_taken_i[retire_ptr_q];
	assign mem_wen_o      = res_mem_wen_i[retire_ptr_q];
	assign mem_wdata_o    = res_mem_wdata_i[retire_ptr_q];
	assign csr_wdata_o    = res_csr_wdata_i[retire_ptr_q];
	assign load_o         = res_load_i[retire_ptr_q];
	assign store_o        = res_store_i[retire_ptr_q];
	assign wd_o           = res_wd_i[retire_ptr_q];
	assign wreg_o         = res_wreg_i[retire_ptr_q];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			retire_ptr_q <= '0;
		end else if (out_valid_o && out_ready_i) begin
			// Wrap after the last lane.
			if (retire_ptr_q == IDX_W'(NUM_LANES - 1)) retire_ptr_q <= '0;
			else retire_ptr_q <= retire_ptr_q + 1'b1;
		end
	end

endmodule

// ==== hdl/exe_cluster_top.sv ====
/*
 * Two-lane RV32I execute cluster: dispatcher, NUM_LANES lanes, retire stage.
 * One decoded op in per handshake, results out in program order.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_cluster_top #(
	parameter int DATA_LEN  = `EXE_DATA_LEN,
	parameter int REG_W     = `EXE_REG_ADDR_W,
	parameter int NUM_LANES = `EXE_NUM_LANES,
	parameter int IDX_W     = `EXE_LANE_IDX_W
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                in_valid_i,
	output logic                in_ready_o,
	input  logic [DATA_LEN-1:0] reg1_i,
	input  logic [DATA_LEN-1:0] reg2_i,
	input  logic [DATA_LEN-1:0] pc_i,
	input  logic [DATA_LEN-1:0] imm_i,
	input  logic [DATA_LEN-1:0] csr_rdata_i,
	input  exe_pkg::alu_op_e    alu_op_i,
	input  exe_pkg::src1_sel_e  src1_sel_i,
	input  exe_pkg::src2_sel_e  src2_sel_i,
	input  exe_pkg::branch_e    branch_i,
	input  exe_pkg::csr_op_e    csr_op_i,
	input  exe_pkg::load_e      load_i,
	input  exe_pkg::store_e     store_i,
	input  logic                wd_i,
	input  logic [REG_W-1:0]    wreg_i,
	output logic                out_valid_o,
	input  logic                out_ready_i,
	output logic [DATA_LEN-1:0] alu_result_o,
	output logic                branch_taken_o,
	output logic                mem_wen_o,
	output logic [DATA_LEN-1:0] mem_wdata_o,
	output logic [DATA_LEN-1:0] csr_wdata_o,
	output exe_pkg::load_e      load_o,
	output exe_pkg::store_e     store_o,
	output logic                wd_o,
	output logic [REG_W-1:0]    wreg_o
);
	import exe_pkg::*;

	logic [NUM_LANES-1:0] lane_valid;
	logic [NUM_LANES-1:0] lane_ready;
	logic [NUM_LANES-1:0] res_valid;
	logic [NUM_LANES-1:0] res_ready;

	// Per-lane result fields into the retire mux.
	logic [DATA_LEN-1:0] lane_alu_result   [NUM_LANES];
	logic                lane_branch_taken [NUM_LANES];
	logic                lane_mem_wen      [NUM_LANES];
	logic [DATA_LEN-1:0] lane_mem_wdata    [NUM_LANES];
	logic [DATA_LEN-1:0] lane_csr_wdata    [NUM_LANES];
	load_e               lane_load         [NUM_LANES];
	store_e              lane_store        [NUM_LANES];
	logic                lane_wd           [NUM_LANES];
	logic [REG_W-1:0]    lane_wreg         [NUM_LANES];

	exe_dispatch #(.NUM_LANES(NUM_LANES), .IDX_W(IDX_W)) dispatch_i (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.lane_valid_o (lane_valid),
		.lane_ready_i (lane_ready)
	);

	// Payload fans out to every lane. Only the issued one captures it.
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		exe_lane #(.DATA_LEN(DATA_LEN), .REG_W(REG_W)) lane_i (
			.clk_i          (clk_i),
			.arst_n_i       (arst_n_i),
			.valid_i        (lane_valid[g]),
			.ready_o        (lane_ready[g]),
			.reg1_i         (reg1_i),
			.reg2_i         (reg2_i),
			.pc_i           (pc_i),
			.imm_i          (imm_i),
			.csr_rdata_i    (csr_rdata_i),
			.alu_op_i       (alu_op_i),
			.src1_sel_i     (src1_sel_i),
			.src2_sel_i     (src2_sel_i),
			.branch_i       (branch_i),
			.csr_op_i       (csr_op_i),
			.load_i         (load_i),
			.store_i        (store_i),
			.wd_i           (wd_i),
			.wreg_i         (wreg_i),
			.res_valid_o    (res_valid[g]),
			.res_ready_i    (res_ready[g]),
			.alu_result_o   (lane_alu_result[g]),
			.branch_taken_o (lane_branch_taken[g]),
			.mem_wen_o      (lane_mem_wen[g]),
			.mem_wdata_o    (lane_mem_wdata[g]),
			.csr_wdata_o    (lane_csr_wdata[g]),
			.load_o         (lane_load[g]),
			.store_o        (lane_store[g]),
			.wd_o           (lane_wd[g]),
			.wreg_o         (lane_wreg[g])
		);
	end

	exe_retire #(
		.DATA_LEN  (DATA_LEN),
		.REG_W     (REG_W),
		.NUM_LANES (NUM_LANES),
		.IDX_W     (IDX_W)
	) retire_i (
		.clk_i              (clk_i),
		.arst_n_i           (arst_n_i),
		.res_valid_i        (res_valid),
		.res_ready_o        (res_ready),
		.res_alu_result_i   (lane_alu_result),
		.res_branch_taken_i (lane_branch_taken),
		.res_mem_wen_i      (lane_mem_wen),
		.res_mem_wdata_i    (lane_mem_wdata),
		.res_csr_wdata_i    (lane_csr_wdata),
		.res_load_i         (lane_load),
		.res_store_i        (lane_store),
		.res_wd_i           (lane_wd),
		.res_wreg_i         (lane_wreg),
		.out_valid_o        (out_valid_o),
		.out_ready_i        (out_ready_i),
		.alu_result_o       (alu_result_o),
		.branch_taken_o     (branch_taken_o),
		.mem_wen_o          (mem_wen_o),
		.mem_wdata_o        (mem_wdata_o),
		.csr_wdata_o        (csr_wdata_o),
		.load_o             (load_o),
		.store_o            (store_o),
		.wd_o               (wd_o),
		.wreg_o             (wreg_o)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * Clock and reset source for the testbench.
 * Free-running clock; active-low reset released after RST_CYCLES rising edges.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 5
) (
	output logic clk_o,
	output logic arst_n_o
);
	logic clk    = 1'b0;
	logic arst_n = 1'b0;

	assign clk_o    = clk;
	assign arst_n_o = arst_n;

	always #(PERIOD_NS / 2) clk = ~clk;

	initial begin
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1; // Released on a rising edge.
	end

endmodule

// ==== verification/exe_cluster_assertions.sv ====
/*
 * Handshake and reset properties of the execute cluster.
 * Bound to exe_cluster_top from the testbench; fail_count is read at the end of the run.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_cluster_assertions #(
	parameter int DATA_LEN  = `EXE_DATA_LEN,
	parameter int REG_W     = `EXE_REG_ADDR_W,
	parameter int NUM_LANES = `EXE_NUM_LANES
) (
	input logic                 clk_i,
	input logic                 arst_n_i,
	input logic                 in_valid_i,
	input logic                 in_ready_i,
	input logic                 out_valid_i,
	input logic                 out_ready_i,
	input logic [DATA_LEN-1:0]  alu_result_i,
	input logic                 branch_taken_i,
	input logic                 mem_wen_i,
	input logic [DATA_LEN-1:0]  mem_wdata_i,
	input logic [DATA_LEN-1:0]  csr_wdata_i,
	input exe_pkg::load_e       load_i,
	input exe_pkg::store_e      store_i,
	input logic                 wd_i,
	input logic [REG_W-1:0]     wreg_i,
	input logic [NUM_LANES-1:0] res_valid_i
);
	localparam int PAY_W = 3 * DATA_LEN + 3 + 3 + 2 + REG_W;

	int unsigned      fail_count = 0;
	logic [PAY_W-1:0] payload;

	assign payload = {alu_result_i, branch_taken_i, mem_wen_i, mem_wdata_i, csr_wdata_i,
		load_i, store_i, wd_i, wreg_i};

	// Stalled output holds valid and every field.
	out_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(payload))
		else begin
			fail_count++;
			$error("output valid or payload changed while stalled");
		end

	reset_state_a: assert property (@(posedge clk_i)
		$rose(arst_n_i) |-> !out_valid_i && in_ready_i)
		else begin
			fail_count++;
			$error("wrong handshake state after reset");
		end

	// Empty cluster, sink ready: one cycle to the output.
	latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		in_valid_i && in_ready_i && out_ready_i && (res_valid_i == '0) |=> out_valid_i)
		else begin
			fail_count++;
			$error("accepted operation did not reach the output on the next cycle");
		end

endmodule

// ==== verification/exe_cluster_tb.sv ====
/*
 * Testbench for the execute cluster with random operations over all encodings,
 * a reference model and an in-order scoreboard. Handshake checks are in the bound assertions.
 */
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_cluster_tb;
	import exe_pkg::*;

	localparam int          DW      = `EXE_DATA_LEN;
	localparam int          REG_W   = `EXE_REG_ADDR_W;
	localparam logic [31:0] SEED    = 32'hc9e2b929;
	localparam int          N_ALU   = 11 * 4 * 4;
	localparam int          N_BR    = 7 * 3 * 4;
	localparam int          N_CSR   = 60;
	localparam int          N_STALL = 200;
	localparam int          N_OPS   = N_ALU + N_BR + N_CSR + N_STALL;
	localparam int          WDOG_CYCLES = N_OPS * 20 + `EXE_WDOG_MARGIN + 5;

	typedef struct packed {
		logic [DW-1:0]    reg1;
		logic [DW-1:0]    reg2;
		logic [DW-1:0]    pc;
		logic [DW-1:0]    imm;
		logic [DW-1:0]    csr_rdata;
		logic [3:0]       alu_op;
		logic [1:0]       src1_sel;
		logic [1:0]       src2_sel;
		logic [2:0]       branch;
		logic [1:0]       csr_op;
		logic [2:0]       load;
		logic [1:0]       store;
		logic             wd;
		logic [REG_W-1:0] wreg;
	} op_t;

	typedef struct packed {
		logic [DW-1:0]    alu_result;
		logic             branch_taken;
		logic             mem_wen;
		logic [DW-1:0]    mem_wdata;
		logic [DW-1:0]    csr_wdata;
		logic [2:0]       load;
		logic [1:0]       store;
		logic             wd;
		logic [REG_W-1:0] wreg;
	} res_t;

	logic             clk;
	logic             arst_n;
	logic             in_valid_i  = 1'b0;
	logic             in_ready_o;
	logic [DW-1:0]    reg1_i      = '0;
	logic [DW-1:0]    reg2_i      = '0;
	logic [DW-1:0]    pc_i        = '0;
	logic [DW-1:0]    imm_i       = '0;
	logic [DW-1:0]    csr_rdata_i = '0;
	alu_op_e          alu_op_i    = ALU_ADD;
	src1_sel_e        src1_sel_i  = SRC1_ZERO;
	src2_sel_e        src2_sel_i  = SRC2_ZERO;
	branch_e          branch_i    = BRANCH_NONE;
	csr_op_e          csr_op_i    = CSR_NONE;
	load_e            load_i      = LOAD_NONE;
	store_e           store_i     = STORE_NONE;
	logic             wd_i        = 1'b0;
	logic [REG_W-1:0] wreg_i      = '0;
	logic             out_valid_o;
	logic             out_ready_i = 1'b1;
	logic [DW-1:0]    alu_result_o;
	logic             branch_taken_o;
	logic             mem_wen_o;
	logic [DW-1:0]    mem_wdata_o;
	logic [DW-1:0]    csr_wdata_o;
	load_e            load_o;
	store_e           store_o;
	logic             wd_o;
	logic [REG_W-1:0] wreg_o;

	res_t  exp_q[$];
	string name_q[$];
	res_t  got_exp;
	string got_name;
	int    errors    = 0;
	int    in_count  = 0;
	int    out_count = 0;
	int    stall_pct = 0; // Chance in percent that out_ready_i is low.
	int    assert_fails;

	tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(5)) clock_gen_i (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	exe_cluster_top dut_i (
		.clk_i    (clk),
		.arst_n_i (arst_n),
		.*
	);

	bind exe_cluster_top exe_cluster_assertions assertions_i (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.in_valid_i     (in_valid_i),
		.in_ready_i     (in_ready_o),
		.out_valid_i    (out_valid_o),
		.out_ready_i    (out_ready_i),
		.alu_result_i   (alu_result_o),
		.branch_taken_i (branch_taken_o),
		.mem_wen_i      (mem_wen_o),
		.mem_wdata_i    (mem_wdata_o),
		.csr_wdata_i    (csr_wdata_o),
		.load_i         (load_o),
		.store_i        (store_o),
		.wd_i           (wd_o),
		.wreg_i         (wreg_o),
		.res_valid_i    (res_valid)
	);

	function automatic logic is_less(input logic [DW-1:0] a, input logic [DW-1:0] b,
		input logic unsigned_cmp);
		if (unsigned_cmp) return a < b;
		return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // Bias the sign bit away.
	endfunction

	// Expected result from the encoding rules.
	function automatic res_t model_op(input op_t op);
		res_t         r;
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		logic [4:0]    sh;
		logic          less;
		logic          zero;
		case (op.src1_sel)
			SRC1_REG1: a = op.reg1;
			SRC1_PC:   a = op.pc;
			SRC1_CSR:  a = op.csr_rdata;
			default:   a = '0;
		endcase
		case (op.src2_sel)
			SRC2_REG2: b = op.reg2;
			SRC2_IMM:  b = op.imm;
			SRC2_FOUR: b = 32'd4;
			default:   b = '0;
		endcase
		sh = b[4:0];
		case (op.alu_op)
			ALU_ADD:   r.alu_result = a + b;
			ALU_SUB:   r.alu_result = a + ~b + 32'd1;
			ALU_AND:   r.alu_result = a & b;
			ALU_OR:    r.alu_result = a | b;
			ALU_XOR:   r.alu_result = a ^ b;
			ALU_SLL:   r.alu_result = a << sh;
			ALU_SRL:   r.alu_result = a >> sh;
			ALU_SRA:   r.alu_result = (a >> sh) | ({DW{a[31]}} & ~(32'hffff_ffff >> sh));
			ALU_SLT:   r.alu_result = {31'd0, is_less(a, b, 1'b0)};
			ALU_SLTU:  r.alu_result = {31'd0, is_less(a, b, 1'b1)};
			ALU_COPY2: r.alu_result = b;
			default:   r.alu_result = '0;
		endcase
		less = is_less(a, b, op.alu_op == ALU_SLTU);
		zero = (r.alu_result == '0);
		case (op.branch)
			BRANCH_BEQ:  r.branch_taken = zero;
			BRANCH_BNE:  r.branch_taken = !zero;
			BRANCH_BLT:  r.branch_taken = less;
			BRANCH_BGE:  r.branch_taken = !less;
			BRANCH_BLTU: r.branch_taken = less;
			BRANCH_BGEU: r.branch_taken = !less;
			default:     r.branch_taken = 1'b0;
		endcase
		case (op.csr_op)
			CSR_RW:  r.csr_wdata = op.reg1;
			CSR_RS:  r.csr_wdata = op.reg1 | op.csr_rdata;
			default: r.csr_wdata = '0;
		endcase
		r.mem_wen   = (op.store != 2'd0);
		r.mem_wdata = op.reg2;
		r.load      = op.load;
		r.store     = op.store;
		r.wd        = op.wd;
		r.wreg      = op.wreg;
		return r;
	endfunction

	function automatic op_t rand_op();
		op_t op;
		op.reg1      = $urandom;
		op.reg2      = $urandom;
		op.pc        = $urandom & 32'hffff_fffc;
		op.imm       = $urandom;
		op.csr_rdata = $urandom;
		op.alu_op    = 4'($urandom_range(10));
		op.src1_sel  = 2'($urandom_range(3));
		op.src2_sel  = 2'($urandom_range(3));
		op.branch    = 3'($urandom_range(6));
		op.csr_op    = 2'($urandom_range(2));
		op.load      = 3'($urandom_range(5));
		op.store     = 2'($urandom_range(3));
		op.wd        = 1'($urandom_range(1));
		op.wreg      = REG_W'($urandom_range(31));
		return op;
	endfunction

	// Called at a rising edge; returns at the edge where the op was taken.
	task automatic send_op(input op_t op, input string tname);
		in_valid_i  <= 1'b1;
		reg1_i      <= op.reg1;
		reg2_i      <= op.reg2;
		pc_i        <= op.pc;
		imm_i       <= op.imm;
		csr_rdata_i <= op.csr_rdata;
		alu_op_i    <= alu_op_e'(op.alu_op);
		src1_sel_i  <= src1_sel_e'(op.src1_sel);
		src2_sel_i  <= src2_sel_e'(op.src2_sel);
		branch_i    <= branch_e'(op.branch);
		csr_op_i    <= csr_op_e'(op.csr_op);
		load_i      <= load_e'(op.load);
		store_i     <= store_e'(op.store);
		wd_i        <= op.wd;
		wreg_i      <= op.wreg;
		do begin
			@(negedge clk);
		end while (!in_ready_o);
		exp_q.push_back(model_op(op));
		name_q.push_back(tname);
		in_count++;
		@(posedge clk);
	endtask

	task automatic idle_gap(input int cycles);
		in_valid_i <= 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic maybe_idle();
		if ($urandom_range(3) == 0) idle_gap(1 + int'($urandom_range(2)));
	endtask

	task automatic check_field(input string tname, input string fname,
		input logic [31:0] expv, input logic [31:0] actv);
		if (expv !== actv) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", tname, fname, expv, actv);
		end
	endtask

	always @(posedge clk) begin
		if (stall_pct == 0) out_ready_i <= 1'b1;
		else out_ready_i <= (int'($urandom_range(99)) >= stall_pct);
	end

	// Output transfer completes on the next rising edge; fields are stable here.
	always @(negedge clk) begin
		if (arst_n && out_valid_o && out_ready_i) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: output transfer with no operation outstanding");
			end else begin
				got_exp  = exp_q.pop_front();
				got_name = name_q.pop_front();
				out_count++;
				check_field(got_name, "alu_result", got_exp.alu_result, alu_result_o);
				check_field(got_name, "branch_taken", 32'(got_exp.branch_taken),
					32'(branch_taken_o));
				check_field(got_name, "mem_wen", 32'(got_exp.mem_wen), 32'(mem_wen_o));
				check_field(got_name, "mem_wdata", got_exp.mem_wdata, mem_wdata_o);
				check_field(got_name, "csr_wdata", got_exp.csr_wdata, csr_wdata_o);
				check_field(got_name, "load", 32'(got_exp.load), 32'(load_o));
				check_field(got_name, "store", 32'(got_exp.store), 32'(store_o));
				check_field(got_name, "wd", 32'(got_exp.wd), 32'(wd_o));
				check_field(got_name, "wreg", 32'(got_exp.wreg), 32'(wreg_o));
			end
		end
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles", WDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		op_t  op;
		logic uns;
		void'($urandom(SEED));
		wait (arst_n == 1'b1);
		@(posedge clk);

		// Every ALU op against every source pairing.
		for (int o = 0; o < 11; o++) begin
			for (int s1 = 0; s1 < 4; s1++) begin
				for (int s2 = 0; s2 < 4; s2++) begin
					op          = rand_op();
					op.alu_op   = 4'(o);
					op.src1_sel = 2'(s1);
					op.src2_sel = 2'(s2);
					op.branch   = BRANCH_NONE;
					send_op(op, "alu_sweep");
					maybe_idle();
				end
			end
		end

		// Branches on equal, less and greater operands.
		for (int br = 0; br < 7; br++) begin
			for (int rel = 0; rel < 3; rel++) begin
				repeat (4) begin
					op          = rand_op();
					op.branch   = 3'(br);
					op.src1_sel = SRC1_REG1;
					op.src2_sel = SRC2_REG2;
					uns         = (op.branch == BRANCH_BLTU || op.branch == BRANCH_BGEU);
					if (op.branch == BRANCH_BLT || op.branch == BRANCH_BGE) begin
						op.alu_op = ALU_SLT;
					end else if (uns) begin
						op.alu_op = ALU_SLTU;
					end else begin
						op.alu_op = ALU_SUB;
					end
					if (op.reg1 == op.reg2) op.reg2 = op.reg1 ^ 32'h1;
					if (rel == 0) op.reg2 = op.reg1;
					else if ((rel == 1) != is_less(op.reg1, op.reg2, uns))
						{op.reg1, op.reg2} = {op.reg2, op.reg1};
					send_op(op, "branch");
					maybe_idle();
				end
			end
		end

		stall_pct = 20;
		for (int i = 0; i < N_CSR; i++) begin
			send_op(rand_op(), "csr_mem");
			maybe_idle();
		end

		stall_pct = 50;
		for (int i = 0; i < N_STALL; i++) begin
			send_op(rand_op(), "stall_order");
			if ($urandom_range(7) == 0) idle_gap(1);
		end

		idle_gap(1);
		stall_pct = 0;
		while (exp_q.size() != 0) @(posedge clk);
		repeat (5) @(posedge clk);

		assert_fails = int'(dut_i.assertions_i.fail_count);
		$display("Errors: %0d compare, %0d assertion; ops %0d in, %0d out, %0d left",
			errors, assert_fails, in_count, out_count, exp_q.size());
		if (errors == 0 && assert_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_lane.sv
hdl/exe_dispatch.sv
hdl/exe_retire.sv
hdl/exe_cluster_top.sv
verification/tb_clock_gen.sv
verification/exe_cluster_assertions.sv
verification/exe_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute cluster testbench with Verilator and run it.
# Exits nonzero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module exe_cluster_tb -o exe_cluster_sim
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

# Let every assertion failure be reported instead of stopping at the first one.
sim_out=$(./obj_dir/exe_cluster_sim +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "run_sim: simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "run_sim: pass line not found in simulation output"
exit 1
